/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := pci_axi_bridge_tb
FILELIST  := files.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* files.f */
+incdir+hw
hw/pci_axi_pkg.sv
hw/pci_target_front.sv
hw/xfer_fifo.sv
hw/axi_lite_engine.sv
hw/pci_axi_bridge.sv
tb/tb_clock_gen.sv
tb/pci_axi_bridge_assertions.sv
tb/pci_axi_bridge_tb.sv

/* hw/axi_lite_engine.sv */
`timescale 1ns/1ps
`include "pci_axi_consts.svh"

module axi_lite_engine
	import pci_axi_pkg::*;
(
	input logic tgt_m_aclk,
	input logic tgt_m_aresetn,

	input logic req_valid,
	input pci_req_t req_item,
	output logic req_pop,

	output logic [31:0] awaddr,
	output logic awvalid,
	input logic awready,

	output logic [`PCI_DATA_W-1:0] wdata,
	output logic [`PCI_BE_W-1:0] wstrb,
	output logic wvalid,
	input logic wready,

	input logic [1:0] bresp,
	input logic bvalid,
	output logic bready,

	output logic [31:0] araddr,
	output logic [`PCI_BE_W-1:0] aruser,
	output logic arvalid,
	input logic arready,

	input logic [`PCI_DATA_W-1:0] rdata,
	input logic [1:0] rresp,
	input logic rvalid,
	output logic rready,

	input logic rsp_full,
	output logic rsp_push,
	output axi_rsp_t rsp_item
);

typedef enum logic [2:0] {EN_IDLE, EN_WRITE, EN_WRESP, EN_RADDR, EN_RDATA} state_t;

state_t state;
logic aw_done;
logic w_done;

// Only take work when there is room for its result
assign req_pop = (state == EN_IDLE) && req_valid && !rsp_full;

// Either channel may finish first
assign aw_done = !awvalid || awready;
assign w_done = !wvalid || wready;

assign bready = (state == EN_WRESP);
assign arvalid = (state == EN_RADDR);
assign rready = (state == EN_RDATA);

assign rsp_push = (bready && bvalid) || (rready && rvalid);

always_comb begin
	if (rready) begin
		rsp_item.data = rdata;
		rsp_item.err = (rresp != `AXI_RESP_OKAY);
	end else begin
		rsp_item.data = '0;
		rsp_item.err = (bresp != `AXI_RESP_OKAY);
	end
end

always_ff @(posedge tgt_m_aclk or negedge tgt_m_aresetn) begin
	if (!tgt_m_aresetn) begin
		state <= EN_IDLE;
		awvalid <= 1'b0;
		wvalid <= 1'b0;
	end else begin
		case (state)
			EN_IDLE: begin
				if (req_pop) begin
					if (req_item.wr) begin
						awvalid <= 1'b1;
						wvalid <= 1'b1;
						state <= EN_WRITE;
					end else begin
						state <= EN_RADDR;
					end
				end
			end
			EN_WRITE: begin
				if (awready)
					awvalid <= 1'b0;
				if (wready)
					wvalid <= 1'b0;
				if (aw_done && w_done)
					state <= EN_WRESP;
			end
			EN_WRESP: begin
				if (bvalid)
					state <= EN_IDLE;
			end
			EN_RADDR: begin
				if (arready)
					state <= EN_RDATA;
			end
			EN_RDATA: begin
				if (rvalid)
					state <= EN_IDLE;
			end
			default: state <= EN_IDLE;
		endcase
	end
end

always_ff @(posedge tgt_m_aclk) begin
	if (req_pop) begin
		awaddr <= req_item.addr;
		wdata <= req_item.data;
		wstrb <= req_item.strb;
		araddr <= req_item.addr;
		aruser <= req_item.strb; // Read enables ride along for the slave
	end
end

endmodule

/* hw/pci_axi_bridge.sv */
`timescale 1ns/1ps
`include "pci_axi_consts.svh"

module pci_axi_bridge
	import pci_axi_pkg::*;
(
	input logic tgt_m_aclk,
	input logic tgt_m_aresetn,

	input logic [31:0] addr,
	output logic [`PCI_DATA_W-1:0] adio_in,
	input logic [`PCI_DATA_W-1:0] adio_out,
	input logic addr_vld,
	input logic [31-`PCI_ADDR_VALID_BITS:0] base_hit,
	output logic s_term,
	output logic s_ready,
	output logic s_abort,
	input logic s_wrdn,
	input logic s_data,
	input logic s_data_vld,
	input logic [`PCI_BE_W-1:0] s_cbe,

	output logic [31:0] tgt_m_awaddr,
	output logic tgt_m_awvalid,
	input logic tgt_m_awready,
	output logic [`PCI_DATA_W-1:0] tgt_m_wdata,
	output logic [`PCI_BE_W-1:0] tgt_m_wstrb,
	output logic tgt_m_wvalid,
	input logic tgt_m_wready,
	input logic [1:0] tgt_m_bresp,
	input logic tgt_m_bvalid,
	output logic tgt_m_bready,
	output logic [31:0] tgt_m_araddr,
	output logic [`PCI_BE_W-1:0] tgt_m_aruser,
	output logic tgt_m_arvalid,
	input logic tgt_m_arready,
	input logic [`PCI_DATA_W-1:0] tgt_m_rdata,
	input logic [1:0] tgt_m_rresp,
	input logic tgt_m_rvalid,
	output logic tgt_m_rready
);

logic req_push;
pci_req_t req_push_item;
logic req_valid;
pci_req_t req_pop_item;
logic req_pop;
logic rsp_push;
axi_rsp_t rsp_push_item;
logic rsp_valid;
axi_rsp_t rsp_pop_item;
logic rsp_pop;
logic rsp_full;

pci_target_front i_pci_target_front (
	.tgt_m_aclk(tgt_m_aclk),
	.tgt_m_aresetn(tgt_m_aresetn),
	.addr(addr),
	.adio_in(adio_in),
	.adio_out(adio_out),
	.addr_vld(addr_vld),
	.base_hit(base_hit),
	.s_term(s_term),
	.s_ready(s_ready),
	.s_abort(s_abort),
	.s_wrdn(s_wrdn),
	.s_data(s_data),
	.s_data_vld(s_data_vld),
	.s_cbe(s_cbe),
	.req_push(req_push),
	.req_item(req_push_item),
	.rsp_valid(rsp_valid),
	.rsp_item(rsp_pop_item),
	.rsp_pop(rsp_pop)
);

// The front end never has more than one request in flight of its own
xfer_fifo #(.payload_t(pci_req_t)) i_req_fifo (
	.tgt_m_aclk(tgt_m_aclk),
	.tgt_m_aresetn(tgt_m_aresetn),
	.push(req_push),
	.push_item(req_push_item),
	.pop(req_pop),
	.pop_item(req_pop_item),
	.valid(req_valid),
	.full()
);

xfer_fifo #(.payload_t(axi_rsp_t)) i_rsp_fifo (
	.tgt_m_aclk(tgt_m_aclk),
	.tgt_m_aresetn(tgt_m_aresetn),
	.push(rsp_push),
	.push_item(rsp_push_item),
	.pop(rsp_pop),
	.pop_item(rsp_pop_item),
	.valid(rsp_valid),
	.full(rsp_full)
);

axi_lite_engine i_axi_lite_engine (
	.tgt_m_aclk(tgt_m_aclk),
	.tgt_m_aresetn(tgt_m_aresetn),
	.req_valid(req_valid),
	.req_item(req_pop_item),
	.req_pop(req_pop),
	.awaddr(tgt_m_awaddr),
	.awvalid(tgt_m_awvalid),
	.awready(tgt_m_awready),
	.wdata(tgt_m_wdata),
	.wstrb(tgt_m_wstrb),
	.wvalid(tgt_m_wvalid),
	.wready(tgt_m_wready),
	.bresp(tgt_m_bresp),
	.bvalid(tgt_m_bvalid),
	.bready(tgt_m_bready),
	.araddr(tgt_m_araddr),
	.aruser(tgt_m_aruser),
	.arvalid(tgt_m_arvalid),
	.arready(tgt_m_arready),
	.rdata(tgt_m_rdata),
	.rresp(tgt_m_rresp),
	.rvalid(tgt_m_rvalid),
	.rready(tgt_m_rready),
	.rsp_full(rsp_full),
	.rsp_push(rsp_push),
	.rsp_item(rsp_push_item)
);

endmodule

/* hw/pci_axi_consts.svh */
`ifndef PCI_AXI_CONSTS_SVH
`define PCI_AXI_CONSTS_SVH

// Low PCI address bits kept, the rest of the AXI address is the base-hit vector
`define PCI_ADDR_VALID_BITS 24

`define PCI_DATA_W 32
`define PCI_BE_W 4

// Entries in each of the request and response buffers
`define FIFO_DEPTH 2

`define AXI_RESP_OKAY 2'b00

`endif

/* hw/pci_axi_pkg.sv */
`include "pci_axi_consts.svh"

package pci_axi_pkg;

	// One PCI transaction handed to the AXI side
	typedef struct packed {
		logic wr; // High for a write
		logic [31:0] addr;
		logic [`PCI_DATA_W-1:0] data;
		logic [`PCI_BE_W-1:0] strb;
	} pci_req_t;

	// Result of one AXI transaction
	typedef struct packed {
		logic [`PCI_DATA_W-1:0] data; // Zero for writes
		logic err; // Response code was not OKAY
	} axi_rsp_t;

endpackage

/* hw/pci_target_front.sv */
`timescale 1ns/1ps
`include "pci_axi_consts.svh"

module pci_target_front
	import pci_axi_pkg::*;
(
	input logic tgt_m_aclk,
	input logic tgt_m_aresetn,

	input logic [31:0] addr,
	output logic [`PCI_DATA_W-1:0] adio_in,
	input logic [`PCI_DATA_W-1:0] adio_out,
	input logic addr_vld,
	input logic [31-`PCI_ADDR_VALID_BITS:0] base_hit,
	output logic s_term,
	output logic s_ready,
	output logic s_abort,
	input logic s_wrdn,
	input logic s_data,
	input logic s_data_vld,
	input logic [`PCI_BE_W-1:0] s_cbe,

	output logic req_push,
	output pci_req_t req_item,
	input logic rsp_valid,
	input axi_rsp_t rsp_item,
	output logic rsp_pop
);

typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_WAIT, ST_DONE} state_t;

state_t state;
logic [31:0] addr_q;
logic [31:0] addr_sel;
logic [1:0] lane;
logic [2:0] drop_cnt; // Responses still owed to abandoned transactions
logic start;
logic take;
logic drop;
logic abandon;
logic finish;

// The address phase may come a cycle ahead of the base hit
assign addr_sel = addr_vld ? addr : addr_q;

assign start = (state == ST_IDLE) && (base_hit != '0);
assign take = rsp_valid && !rsp_pop; // The pop of the last cycle is not yet seen in rsp_valid
assign drop = take && (drop_cnt != 3'd0);
assign abandon = !s_data && (state == ST_ISSUE || state == ST_WAIT);
assign finish = (state == ST_WAIT) && s_data && take && (drop_cnt == 3'd0);

assign req_push = (state == ST_ISSUE);

// PCI only counts up from the address, AXI wants the real byte position
always_comb begin
	casez (s_cbe)
		4'b???0: lane = 2'd0;
		4'b??01: lane = 2'd1;
		4'b?011: lane = 2'd2;
		4'b0111: lane = 2'd3;
		default: lane = 2'd0;
	endcase
end

always_ff @(posedge tgt_m_aclk) begin
	if (addr_vld)
		addr_q <= addr;
	if (start) begin
		req_item.wr <= s_wrdn;
		req_item.addr <= {base_hit, addr_sel[`PCI_ADDR_VALID_BITS-1:2], lane};
		req_item.data <= adio_out;
		req_item.strb <= ~s_cbe; // Enables are active low on PCI
	end
	if (finish && !req_item.wr)
		adio_in <= rsp_item.data;
end

always_ff @(posedge tgt_m_aclk or negedge tgt_m_aresetn) begin
	if (!tgt_m_aresetn) begin
		state <= ST_IDLE;
		s_term <= 1'b0;
		s_ready <= 1'b0;
		s_abort <= 1'b0;
		rsp_pop <= 1'b0;
		drop_cnt <= 3'd0;
	end else begin
		rsp_pop <= drop || finish;
		drop_cnt <= drop_cnt + {2'b00, abandon} - {2'b00, drop};

		case (state)
			ST_IDLE: begin
				if (start)
					state <= ST_ISSUE;
			end
			ST_ISSUE: begin
				state <= s_data ? ST_WAIT : ST_IDLE;
			end
			ST_WAIT: begin
				if (!s_data) begin
					state <= ST_IDLE;
				end else if (finish) begin
					s_term <= 1'b1;
					s_ready <= !rsp_item.err;
					s_abort <= rsp_item.err;
					state <= ST_DONE;
				end
			end
			ST_DONE: begin
				// Hold the termination until the master takes it or gives up
				if (s_data_vld || !s_data) begin
					s_term <= 1'b0;
					s_ready <= 1'b0;
					s_abort <= 1'b0;
					state <= ST_IDLE;
				end
			end
			default: state <= ST_IDLE;
		endcase
	end
end

endmodule

/* hw/xfer_fifo.sv */
`timescale 1ns/1ps
`include "pci_axi_consts.svh"

module xfer_fifo #(
	parameter type payload_t = logic [7:0]
) (
	input logic tgt_m_aclk,
	input logic tgt_m_aresetn,
	input logic push,
	input payload_t push_item,
	input logic pop,
	output payload_t pop_item,
	output logic valid,
	output logic full
);

localparam int DEPTH = `FIFO_DEPTH;
localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CNT_W = $clog2(DEPTH + 1);

payload_t mem [DEPTH];
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [CNT_W-1:0] count;
logic do_push;
logic do_pop;

// Wraps at DEPTH, which need not be a power of two
function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
	return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
endfunction

assign do_push = push && !full;
assign do_pop = pop && valid;

assign valid = (count != '0);
assign full = (count == CNT_W'(DEPTH));
assign pop_item = mem[rd_ptr];

always_ff @(posedge tgt_m_aclk) begin
	if (do_push)
		mem[wr_ptr] <= push_item;
end

always_ff @(posedge tgt_m_aclk or negedge tgt_m_aresetn) begin
	if (!tgt_m_aresetn) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
	end else begin
		if (do_push)
			wr_ptr <= ptr_inc(wr_ptr);
		if (do_pop)
			rd_ptr <= ptr_inc(rd_ptr);
		case ({do_push, do_pop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count; // Both or neither leave the level alone
		endcase
	end
end

endmodule

/* tb/pci_axi_bridge_assertions.sv */
`timescale 1ns/1ps

module pci_axi_bridge_assertions (
	input logic tgt_m_aclk,
	input logic tgt_m_aresetn,
	input logic tgt_m_awvalid,
	input logic tgt_m_awready,
	input logic tgt_m_wvalid,
	input logic tgt_m_wready,
	input logic tgt_m_arvalid,
	input logic tgt_m_arready,
	input logic s_ready,
	input logic s_abort
);

// Outputs stay quiet while reset is applied
a_reset_quiet: assert property (@(posedge tgt_m_aclk)
	!tgt_m_aresetn |-> (!tgt_m_awvalid && !tgt_m_arvalid && !s_ready))
	else $error("AXI valid or s_ready high during reset");

a_aw_hold: assert property (@(posedge tgt_m_aclk) disable iff (!tgt_m_aresetn)
	(tgt_m_awvalid && !tgt_m_awready) |=> tgt_m_awvalid)
	else $error("awvalid dropped before awready");

a_w_hold: assert property (@(posedge tgt_m_aclk) disable iff (!tgt_m_aresetn)
	(tgt_m_wvalid && !tgt_m_wready) |=> tgt_m_wvalid)
	else $error("wvalid dropped before wready");

a_ar_hold: assert property (@(posedge tgt_m_aclk) disable iff (!tgt_m_aresetn)
	(tgt_m_arvalid && !tgt_m_arready) |=> tgt_m_arvalid)
	else $error("arvalid dropped before arready");

a_ready_abort: assert property (@(posedge tgt_m_aclk) disable iff (!tgt_m_aresetn)
	!(s_ready && s_abort))
	else $error("s_ready and s_abort high together");

endmodule

bind pci_axi_bridge pci_axi_bridge_assertions i_pci_axi_bridge_assertions (.*);

/* tb/pci_axi_bridge_tb.sv */
`timescale 1ns/1ps
`include "pci_axi_consts.svh"

module pci_axi_bridge_tb
	import pci_axi_pkg::*;
;

logic clk;
logic rstn;
logic [31:0] addr;
logic [31:0] adio_in;
logic [31:0] adio_out;
logic addr_vld;
logic [7:0] base_hit;
logic s_term;
logic s_ready;
logic s_abort;
logic s_wrdn;
logic s_data;
logic s_data_vld;
logic [3:0] s_cbe;
logic [31:0] awaddr;
logic awvalid;
logic awready;
logic [31:0] wdata;
logic [3:0] wstrb;
logic wvalid;
logic wready;
logic [1:0] bresp;
logic bvalid;
logic bready;
logic [31:0] araddr;
logic [3:0] aruser;
logic arvalid;
logic arready;
logic [31:0] rdata;
logic [1:0] rresp;
logic rvalid;
logic rready;

logic [31:0] mem [256];
logic [31:0] cap_awaddr;
logic [31:0] cap_wdata;
logic [3:0] cap_wstrb;
logic [31:0] cap_araddr;
logic [3:0] cap_aruser;
logic aw_pend;
logic w_pend;
integer aw_cnt;
integer w_cnt;
integer ar_cnt;
integer b_cnt;
integer r_cnt;
integer cur_delay;
logic [1:0] cur_resp;
integer seed;
integer errors;

tb_clock_gen i_tb_clock_gen (.tgt_m_aclk(clk), .tgt_m_aresetn(rstn));

pci_axi_bridge i_pci_axi_bridge (
	.tgt_m_aclk(clk), .tgt_m_aresetn(rstn),
	.addr(addr), .adio_in(adio_in), .adio_out(adio_out), .addr_vld(addr_vld),
	.base_hit(base_hit), .s_term(s_term), .s_ready(s_ready), .s_abort(s_abort),
	.s_wrdn(s_wrdn), .s_data(s_data), .s_data_vld(s_data_vld), .s_cbe(s_cbe),
	.tgt_m_awaddr(awaddr), .tgt_m_awvalid(awvalid), .tgt_m_awready(awready),
	.tgt_m_wdata(wdata), .tgt_m_wstrb(wstrb), .tgt_m_wvalid(wvalid),
	.tgt_m_wready(wready), .tgt_m_bresp(bresp), .tgt_m_bvalid(bvalid),
	.tgt_m_bready(bready), .tgt_m_araddr(araddr), .tgt_m_aruser(aruser),
	.tgt_m_arvalid(arvalid), .tgt_m_arready(arready), .tgt_m_rdata(rdata),
	.tgt_m_rresp(rresp), .tgt_m_rvalid(rvalid), .tgt_m_rready(rready)
);

// A negative delay field asks for a random ready delay of 0 to 3 cycles
function automatic integer pick_delay();
	integer d;
	if (cur_delay < 0)
		d = {$random(seed)} % 4;
	else
		d = cur_delay;
	return d;
endfunction

task automatic wait_cycles(input integer n);
	repeat (n) begin
		@(posedge clk);
		#2;
	end
endtask

task automatic check_req(input integer t, input pci_req_t got, input pci_req_t exp);
	string a_name;
	string s_name;
	if (exp.wr) begin
		a_name = "tgt_m_awaddr";
		s_name = "tgt_m_wstrb";
	end else begin
		a_name = "tgt_m_araddr";
		s_name = "tgt_m_aruser";
	end
	if (got.addr !== exp.addr) begin
		$display("Fail test %0d %s got %h expected %h", t, a_name, got.addr, exp.addr);
		errors = errors + 1;
	end
	if (got.strb !== exp.strb) begin
		$display("Fail test %0d %s got %h expected %h", t, s_name, got.strb, exp.strb);
		errors = errors + 1;
	end
	if (exp.wr && got.data !== exp.data) begin
		$display("Fail test %0d tgt_m_wdata got %h expected %h", t, got.data, exp.data);
		errors = errors + 1;
	end
endtask

task automatic check_rsp(input integer t, input axi_rsp_t got, input axi_rsp_t exp,
	input bit has_data);
	if (got.err !== exp.err) begin
		$display("Fail test %0d s_abort got %h expected %h", t, got.err, exp.err);
		errors = errors + 1;
	end
	if (has_data && got.data !== exp.data) begin
		$display("Fail test %0d adio_in got %h expected %h", t, got.data, exp.data);
		errors = errors + 1;
	end
endtask

initial begin
	for (int i = 0; i < 256; i++)
		mem[i] = {8'ha5, i[7:0], ~i[7:0], i[7:0] ^ 8'h3c};
end

// Slave address and data channels
initial begin
	awready = 1'b0;
	aw_pend = 1'b0;
	aw_cnt = 0;
	forever begin
		wait_cycles(1);
		if (awvalid && !aw_pend) begin
			wait_cycles(pick_delay());
			cap_awaddr = awaddr;
			awready = 1'b1;
			wait_cycles(1);
			awready = 1'b0;
			aw_pend = 1'b1;
			aw_cnt = aw_cnt + 1;
		end
	end
end

initial begin
	wready = 1'b0;
	w_pend = 1'b0;
	w_cnt = 0;
	forever begin
		wait_cycles(1);
		if (wvalid && !w_pend) begin
			wait_cycles(pick_delay());
			cap_wdata = wdata;
			cap_wstrb = wstrb;
			wready = 1'b1;
			wait_cycles(1);
			wready = 1'b0;
			w_pend = 1'b1;
			w_cnt = w_cnt + 1;
		end
	end
end

// Write response after both beats, with the memory merged by strobe
initial begin
	integer n;
	bvalid = 1'b0;
	bresp = 2'b00;
	b_cnt = 0;
	forever begin
		wait_cycles(1);
		if (aw_pend && w_pend) begin
			if (cur_resp == `AXI_RESP_OKAY) begin
				for (int b = 0; b < 4; b++)
					if (cap_wstrb[b])
						mem[cap_awaddr[9:2]][8*b +: 8] = cap_wdata[8*b +: 8];
			end
			bresp = cur_resp;
			bvalid = 1'b1;
			n = 0;
			while (!bready && n < 200) begin
				wait_cycles(1);
				n = n + 1;
			end
			if (n >= 200) begin
				$display("Slave timed out waiting for bready");
				errors = errors + 1;
			end
			wait_cycles(1);
			bvalid = 1'b0;
			aw_pend = 1'b0;
			w_pend = 1'b0;
			b_cnt = b_cnt + 1;
		end
	end
end

initial begin
	integer n;
	arready = 1'b0;
	rvalid = 1'b0;
	rdata = '0;
	rresp = 2'b00;
	ar_cnt = 0;
	r_cnt = 0;
	forever begin
		wait_cycles(1);
		if (arvalid) begin
			wait_cycles(pick_delay());
			cap_araddr = araddr;
			cap_aruser = aruser;
			arready = 1'b1;
			wait_cycles(1);
			arready = 1'b0;
			ar_cnt = ar_cnt + 1;
			rdata = (cur_resp == `AXI_RESP_OKAY) ? mem[cap_araddr[9:2]] : 32'h0;
			rresp = cur_resp;
			rvalid = 1'b1;
			n = 0;
			while (!rready && n < 200) begin
				wait_cycles(1);
				n = n + 1;
			end
			if (n >= 200) begin
				$display("Slave timed out waiting for rready");
				errors = errors + 1;
			end
			wait_cycles(1);
			rvalid = 1'b0;
			r_cnt = r_cnt + 1;
		end
	end
end

initial begin
	integer fd;
	integer code;
	integer op;
	integer dly;
	integer tnum;
	integer n;
	integer n_pass;
	integer n_fail;
	integer err0;
	integer aw0;
	integer w0;
	integer b0;
	integer ar0;
	integer r0;
	bit stop;
	bit seen;
	string line;
	logic [7:0] t_bh;
	logic [31:0] t_addr;
	logic [3:0] t_cbe;
	logic [31:0] t_wdata;
	logic [1:0] t_resp;
	logic [31:0] e_addr;
	logic [3:0] e_strb;
	logic [31:0] e_data;
	pci_req_t got_req;
	pci_req_t exp_req;
	axi_rsp_t got_rsp;
	axi_rsp_t exp_rsp;

	seed = 43105;
	errors = 0;
	cur_delay = 0;
	cur_resp = 2'b00;
	addr = '0;
	adio_out = '0;
	addr_vld = 1'b0;
	base_hit = '0;
	s_wrdn = 1'b0;
	s_data = 1'b0;
	s_data_vld = 1'b0;
	s_cbe = 4'hf;
	tnum = 0;
	n_pass = 0;
	n_fail = 0;
	stop = 1'b0;

	fd = $fopen("tb/pci_axi_tests.txt", "r");
	if (fd == 0) begin
		$display("Could not open the test file");
		errors = errors + 1;
		stop = 1'b1;
	end
	n = 0;
	while (rstn !== 1'b1 && n < 200) begin
		wait_cycles(1);
		n = n + 1;
	end
	if (rstn !== 1'b1) begin
		$display("Timed out waiting for reset to be released");
		errors = errors + 1;
		stop = 1'b1;
	end
	wait_cycles(2);

	while (!stop && !$feof(fd)) begin
		code = $fgets(line, fd);
		if (code == 0 || line.len() < 2 || line[0] == "#")
			continue;
		code = $sscanf(line, "%d %h %h %h %h %d %h %h %h %h", op, t_bh, t_addr, t_cbe,
			t_wdata, dly, t_resp, e_addr, e_strb, e_data);
		if (code != 10)
			continue;
		tnum = tnum + 1;
		err0 = errors;
		cur_delay = dly;
		cur_resp = t_resp;
		aw0 = aw_cnt;
		w0 = w_cnt;
		b0 = b_cnt;
		ar0 = ar_cnt;
		r0 = r_cnt;

		addr = t_addr;
		addr_vld = 1'b1;
		base_hit = t_bh;
		s_wrdn = (op == 0);
		s_cbe = t_cbe;
		adio_out = t_wdata;
		s_data = 1'b1;
		wait_cycles(1);
		addr_vld = 1'b0;
		base_hit = '0;

		if (op == 2) begin
			// No base hit, so the bus must stay idle
			s_data = 1'b0;
			seen = 1'b0;
			for (int i = 0; i < 200; i++) begin
				if (awvalid || arvalid || s_ready || s_abort)
					seen = 1'b1;
				wait_cycles(1);
			end
			if (seen || aw_cnt != aw0 || ar_cnt != ar0) begin
				$display("Test %0d saw bus activity without a base hit", tnum);
				errors = errors + 1;
			end
		end else if (op == 3) begin
			s_data = 1'b0; // Master gives up before the response
			n = 0;
			seen = 1'b0;
			while (r_cnt == r0 && n < 200) begin
				if (s_ready || s_abort)
					seen = 1'b1;
				wait_cycles(1);
				n = n + 1;
			end
			if (n >= 200) begin
				$display("Test %0d timed out waiting for the abandoned read", tnum);
				errors = errors + 1;
				stop = 1'b1;
			end
			wait_cycles(4);
			if (seen || s_ready || s_abort) begin
				$display("Test %0d completed an abandoned transaction", tnum);
				errors = errors + 1;
			end
			check_req(tnum, {1'b0, cap_araddr, 32'h0, cap_aruser},
				{1'b0, e_addr, 32'h0, e_strb});
		end else begin
			n = 0;
			while (!(s_ready || s_abort) && n < 200) begin
				wait_cycles(1);
				n = n + 1;
			end
			if (n >= 200) begin
				$display("Test %0d timed out waiting for s_ready or s_abort", tnum);
				errors = errors + 1;
				stop = 1'b1;
			end else begin
				if (!s_term) begin
					$display("Test %0d ended without s_term", tnum);
					errors = errors + 1;
				end
				got_rsp.err = s_abort;
				got_rsp.data = adio_in;
				exp_rsp.err = (t_resp != `AXI_RESP_OKAY);
				exp_rsp.data = e_data;
				check_rsp(tnum, got_rsp, exp_rsp, op == 1);
				if (op == 0) begin
					got_req = {1'b1, cap_awaddr, cap_wdata, cap_wstrb};
					exp_req = {1'b1, e_addr, e_data, e_strb};
					if (aw_cnt != aw0 + 1 || w_cnt != w0 + 1 || b_cnt != b0 + 1) begin
						$display("Test %0d saw a wrong number of write beats", tnum);
						errors = errors + 1;
					end
				end else begin
					got_req = {1'b0, cap_araddr, 32'h0, cap_aruser};
					exp_req = {1'b0, e_addr, 32'h0, e_strb};
					if (ar_cnt != ar0 + 1 || r_cnt != r0 + 1) begin
						$display("Test %0d saw a wrong number of read beats", tnum);
						errors = errors + 1;
					end
				end
				check_req(tnum, got_req, exp_req);
			end
			s_data_vld = 1'b1;
			wait_cycles(1);
			s_data_vld = 1'b0;
			s_data = 1'b0;
			wait_cycles(2);
		end

		if (errors == err0) begin
			n_pass = n_pass + 1;
			$display("Test %0d op %0d passed", tnum, op);
		end else begin
			n_fail = n_fail + 1;
			$display("Test %0d op %0d failed", tnum, op);
		end
	end
	if (fd != 0)
		$fclose(fd);

	$display("Tests run %0d passed %0d failed %0d errors %0d", tnum, n_pass, n_fail, errors);
	if (errors == 0 && tnum > 0) begin
		$display("TEST OK");
	end else begin
		$display("TEST FAILED");
	end
	$finish;
end

endmodule

/* tb/pci_axi_tests.txt */
# op(0 wr 1 rd 2 no hit 3 abandon) base_hit addr s_cbe wdata delay resp
# then expected AXI address, strobes and data (hex except op and delay)
0 01 00000010 0 11223344 0 0 01000010 f 11223344
1 01 00000010 0 00000000 0 0 01000010 f 11223344
0 02 00000020 0 00000000 0 0 02000020 f 00000000
0 02 00000020 c aabbccdd 0 0 02000020 3 aabbccdd
0 02 00000020 3 55667788 1 0 02000022 c 55667788
1 02 00000020 0 00000000 0 0 02000020 f 5566ccdd
0 02 00000024 0 01020304 0 0 02000024 f 01020304
0 02 00000024 7 99aabbcc 2 0 02000027 8 99aabbcc
1 02 00000024 0 00000000 1 0 02000024 f 99020304
1 01 00000010 0 00000000 0 2 01000010 f 00000000
0 04 00000040 0 deadbeef 0 3 04000040 f deadbeef
0 01 00000100 0 cafef00d 3 0 01000100 f cafef00d
1 01 00000100 0 00000000 -1 0 01000100 f cafef00d
0 01 00000104 0 0badc0de -1 0 01000104 f 0badc0de
1 01 00000104 0 00000000 2 0 01000104 f 0badc0de
2 00 00000010 0 00000000 0 0 00000000 0 00000000
3 01 00000010 0 00000000 0 0 01000010 f 00000000
1 01 00000100 0 00000000 0 0 01000100 f cafef00d

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic tgt_m_aclk,
	output logic tgt_m_aresetn
);

initial begin
	tgt_m_aclk = 1'b0;
	forever #20 tgt_m_aclk = ~tgt_m_aclk; // 40 ns period
end

initial begin
	tgt_m_aresetn = 1'b0;
	repeat (16) @(posedge tgt_m_aclk);
	#2 tgt_m_aresetn = 1'b1;
end

endmodule
